/* Makefile */
TOP := eboxControlTb

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee run.log
	grep -q "^all tests passed$$" run.log

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean

/* dv/eboxControlTb.sv */
// EBOX control testbench
`timescale 1ns/10ps
`include "ebox_settings.svh"

module eboxControlTb;

  localparam int randomCycles = 600;
  localparam int conoWrites   = 12;
  localparam int consoleOps   = 40;
  localparam int watchdogNs   = (randomCycles + conoWrites + consoleOps * 12) * 10 + 500;

  logic clk;
  logic reset;
  logic [`EBOX_COND_WIDTH-1:0] cond;
  microwordPkg::magicWord magic;
  logic memWait, userMode, publicMode, ioLegalIr, piReady;
  logic mtrIntReq, vmaFetch, mboxCycReq, xfer;
  logic [`EBOX_DATA_WIDTH-1:0] ebusData;
  logic diagReq;
  logic [3:0] diagFunc;
  logic skip, loadIr, run, memCycle, mboxWait, piCycle, diagAck;
  logic [1:0] vmaSel;
  logic [2:0] nicond;
  logic [`EBOX_DATA_WIDTH-1:0] diagRdData;

  logic [31:0] lfsr;
  int errors;
  int checks;

  // Reference model state
  logic modelLook, modelLoad, modelKlPag, modelTrap;
  logic [2:0] modelPar;
  logic modelMem, modelPi;
  logic [3:0] modelUcode;
  logic [2:0] modelNicond;
  logic modelAck, modelRunReq, modelContEv;
  logic [2:0] runPipe;
  logic [2:0] startPipe;
  logic [`EBOX_DATA_WIDTH-1:0] modelRdData;

  eboxControl i_eboxControl (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic randBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], randBit()};
    end
    return value;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  function automatic logic expectSkip();
    logic kernel;
    kernel = !userMode && !publicMode;
    case (cond)
      6'o60: return vmaFetch;
      6'o61: return kernel;
      6'o62: return userMode;
      6'o63: return publicMode;
      6'o64: return modelPi;
      6'o65: return modelMem;
      6'o66: return memWait && modelMem;
      6'o67: return xfer;
      6'o70: return mtrIntReq || piReady;
      6'o71: return !startPipe[2];
      6'o72: return runPipe[2];
      6'o73: return ioLegalIr || kernel;
      6'o74: return mtrIntReq;
      6'o75: return modelTrap;
      6'o76: return modelKlPag;
      6'o77: return modelLook;
      default: return 1'b0;
    endcase
  endfunction

  // Decrement in bit 1, increment in bit 0
  function automatic logic [1:0] expectVmaSel();
    case (cond)
      microwordPkg::condVmaDec: return 2'b10;
      microwordPkg::condVmaInc: return 2'b01;
      default: return 2'b00;
    endcase
  endfunction

  function automatic logic [`EBOX_DATA_WIDTH-1:0] expectStatus(input logic [3:0] func);
    case (func)
      4'd0: return {modelLook, modelLoad, modelKlPag, modelTrap, modelPar, 1'b0};
      4'd1: return {runPipe[2], modelMem, modelPi, memWait && modelMem, 1'b0, modelNicond};
      4'd2: return {modelUcode, 4'b0000};
      default: return '0;
    endcase
  endfunction

  task automatic checkOutputs();
    compareValue("skip", 32'(skip), 32'(expectSkip()));
    compareValue("loadIr", 32'(loadIr),
                 32'(cond == microwordPkg::condLoadIr || (vmaFetch && modelMem)));
    compareValue("vmaSel", 32'(vmaSel), 32'(expectVmaSel()));
    compareValue("run", 32'(run), 32'(runPipe[2]));
    compareValue("start", 32'(i_eboxControl.start), 32'(startPipe[2]));
    compareValue("memCycle", 32'(memCycle), 32'(modelMem));
    compareValue("mboxWait", 32'(mboxWait), 32'(memWait && modelMem));
    compareValue("piCycle", 32'(piCycle), 32'(modelPi));
    compareValue("nicond", 32'(nicond), 32'(modelNicond));
    compareValue("diagAck", 32'(diagAck), 32'(modelAck));
    if (modelAck) begin
      compareValue("diagRdData", 32'(diagRdData), 32'(modelRdData));
    end
  endtask

  // Advance the model across one rising edge, all from pre-edge values
  task automatic updateModel();
    logic take;
    logic conoHit;
    logic specInstr;
    logic [2:0] nicNext;
    take = diagReq && !modelAck;
    conoHit = cond == microwordPkg::condDiagFunc && !magic[2] && magic[5:3] == 3'd1;
    specInstr = cond == microwordPkg::condSpecInstr;
    if (modelPi) nicNext = 3'd1;
    else if (!runPipe[2]) nicNext = 3'd2;
    else if (mtrIntReq) nicNext = 3'd3;
    else if (piReady) nicNext = 3'd4;
    else if (modelUcode[2]) nicNext = 3'd5;
    else nicNext = 3'd0;
    if (take) modelRdData = expectStatus(diagFunc);
    runPipe = {runPipe[1:0], modelRunReq};
    startPipe = {startPipe[1:0], modelContEv};
    modelContEv = take && diagFunc == diagPkg::diagContinue;
    if (take && diagFunc == diagPkg::diagSetRun) modelRunReq = 1'b1;
    if (take && diagFunc == diagPkg::diagClrRun) modelRunReq = 1'b0;
    if (take) modelAck = 1'b1;
    else if (!diagReq) modelAck = 1'b0;
    modelMem = mboxCycReq || (modelMem && !xfer);
    if (specInstr && magic[0]) modelPi = 1'b1;
    else if (specInstr && magic[2]) modelPi = 1'b0;
    if (cond == microwordPkg::condEboxState) begin
      for (int k = 0; k < 4; k++) begin
        modelUcode[k] = magic[2 * k + 1] || (magic[2 * k + 2] && modelUcode[k]);
      end
    end
    if (conoHit && magic[8:6] == 3'd5) modelPar = ebusData[2:0];
    if (conoHit && magic[8:6] == 3'd6) begin
      {modelLook, modelLoad, modelKlPag, modelTrap} = ebusData[3:0];
    end
    modelNicond = nicNext;
  endtask

  task automatic tick();
    @(negedge clk);
    checkOutputs();
    @(posedge clk);
    updateModel();
    #1;
  endtask

  task automatic setIdle();
    cond = '0;
    magic = '0;
    {memWait, userMode, publicMode, ioLegalIr, piReady} = 5'b00000;
    {mtrIntReq, vmaFetch, mboxCycReq, xfer} = 4'b0000;
    ebusData = '0;
  endtask

  task automatic driveRandom();
    case (2'(randBits(2)))
      2'd0: cond = 6'(randBits(6));
      2'd1: cond = randBit() ? microwordPkg::condSpecInstr : microwordPkg::condEboxState;
      2'd2: cond = {2'b11, 4'(randBits(4))};
      default: begin
        case (2'(randBits(2)))
          2'd0: cond = microwordPkg::condLoadIr;
          2'd1: cond = microwordPkg::condVmaDec;
          2'd2: cond = microwordPkg::condVmaInc;
          default: cond = microwordPkg::condDiagFunc;
        endcase
      end
    endcase
    magic = 9'(randBits(9));
    {memWait, userMode, publicMode, ioLegalIr, piReady} = 5'(randBits(5));
    {mtrIntReq, vmaFetch, xfer} = 3'(randBits(3));
    mboxCycReq = 2'(randBits(2)) == 2'd0;
    ebusData = 8'(randBits(8));
  endtask

  // One four-phase console transaction, req held for extra cycles
  task automatic consoleOp(input logic [3:0] func, input int hold);
    int waited;
    diagReq = 1'b1;
    diagFunc = func;
    waited = 0;
    tick();
    while (!diagAck && waited < 10) begin
      tick();
      waited++;
    end
    if (!diagAck) begin
      errors++;
      $display("ERROR at %0t: diagAck never rose for function %b", $time, func);
    end
    repeat (hold) tick();
    diagReq = 1'b0;
    tick();
    waited = 0;
    while (diagAck && waited < 10) begin
      tick();
      waited++;
    end
    if (diagAck) begin
      errors++;
      $display("ERROR at %0t: diagAck stayed high after diagReq dropped", $time);
    end
    repeat (6) tick();
  endtask

  initial begin
    #(watchdogNs);
    $display("ERROR: run did not finish within %0d ns", watchdogNs);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [3:0] func;
    lfsr = 32'h69a72dee;
    errors = 0;
    checks = 0;
    {modelLook, modelLoad, modelKlPag, modelTrap, modelPar} = 7'd0;
    {modelMem, modelPi, modelUcode, modelNicond} = 9'd0;
    {modelAck, modelRunReq, modelContEv, runPipe, startPipe} = 9'd0;
    modelRdData = '0;
    reset = 1'b1;
    diagReq = 1'b0;
    diagFunc = 4'd0;
    setIdle();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    // Outputs come out of reset at zero
    tick();
    consoleOp(diagPkg::diagSetRun, 0);
    repeat (randomCycles) begin
      driveRandom();
      tick();
    end
    setIdle();
    repeat (conoWrites) begin
      cond = microwordPkg::condDiagFunc;
      magic = {randBit() ? 3'd6 : 3'd5, 3'd1, 1'b0, 2'(randBits(2))};
      ebusData = 8'(randBits(8));
      tick();
      setIdle();
      consoleOp(4'd0, int'(randBits(2)));
    end
    consoleOp(4'd1, 1);
    consoleOp(4'd2, 0);
    consoleOp(4'd5, 2);
    repeat (consoleOps - conoWrites - 4) begin
      case (3'(randBits(3)))
        3'd0: func = diagPkg::diagSetRun;
        3'd1: func = diagPkg::diagClrRun;
        3'd2: func = diagPkg::diagContinue;
        3'd3: func = 4'(randBits(4));
        default: func = {1'b0, 3'(randBits(2))};
      endcase
      consoleOp(func, int'(randBits(2)));
    end
    errors += i_eboxControl.i_chk.assertFails;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* dv/eboxControl_chk.sv */
// Console and start checks
`timescale 1ns/10ps

module eboxControl_chk (
  input logic clk,
  input logic reset,
  input logic diagReq,
  input logic diagAck,
  input logic start
);

  int assertFails = 0;

  ackRise: assert property (@(posedge clk) disable iff (reset)
    $rose(diagAck) |-> $past(diagReq))
    else begin
      assertFails++;
      $error("diagAck rose without a pending request");
    end

  ackFall: assert property (@(posedge clk) disable iff (reset)
    $fell(diagAck) |-> !$past(diagReq))
    else begin
      assertFails++;
      $error("diagAck fell while diagReq was still high");
    end

  // START is a single-cycle pulse
  startPulse: assert property (@(posedge clk) disable iff (reset)
    start |=> !start)
    else begin
      assertFails++;
      $error("start held high for two cycles");
    end

endmodule

bind eboxControl eboxControl_chk i_chk (
  .clk(clk), .reset(reset), .diagReq(diagReq), .diagAck(diagAck), .start(start)
);

/* filelist.f */
+incdir+source
source/microwordPkg.sv
source/diagPkg.sv
source/condDecoder.sv
source/conoRegisters.sv
source/cycleControl.sv
source/diagConsole.sv
source/eboxControl.sv
dv/eboxControl_chk.sv
dv/eboxControlTb.sv

/* source/condDecoder.sv */
// Condition field decoder
`timescale 1ns/10ps
`include "ebox_settings.svh"

module condDecoder (
  input  logic [`EBOX_COND_WIDTH-1:0] cond,
  input  logic                        userMode,
  input  logic                        publicMode,
  input  logic                        ioLegalIr,
  input  logic                        piReady,
  input  logic                        mtrIntReq,
  input  logic                        vmaFetch,
  input  logic                        memCycle,
  input  logic                        mboxWait,
  input  logic                        xfer,
  input  logic                        piCycle,
  input  logic                        run,
  input  logic                        start,
  input  logic                        trapEn,
  input  logic                        klPagingEn,
  input  logic                        cacheLookEn,
  output logic                        skip,
  output logic                        loadIr,
  output logic [1:0]                  vmaSel
);

  logic [2:0] condGroup;
  logic [2:0] condSelect;
  logic       kernel;
  logic       intReq;
  logic       ioLegal;
  logic [7:0] skip60;
  logic [7:0] skip70;

  assign condGroup  = cond[`EBOX_COND_WIDTH-1 -: 3];
  assign condSelect = cond[2:0];

  assign kernel  = ~userMode & ~publicMode;
  assign intReq  = mtrIntReq | piReady;
  assign ioLegal = ioLegalIr | kernel;

  // Skip sources, select 0 in bit 0
  assign skip60 = {xfer, mboxWait, memCycle, piCycle,
                   publicMode, userMode, kernel, vmaFetch};
  assign skip70 = {cacheLookEn, klPagingEn, trapEn, mtrIntReq,
                   ioLegal, run, ~start, intReq};

  always_comb begin
    case (condGroup)
      microwordPkg::condGroupSkip60: skip = skip60[condSelect];
      microwordPkg::condGroupSkip70: skip = skip70[condSelect];
      default:                       skip = 1'b0;
    endcase
  end

  // Fetch cycles load IR as well
  assign loadIr = (cond == microwordPkg::condLoadIr) | (vmaFetch & memCycle);

  assign vmaSel = {cond == microwordPkg::condVmaDec,
                   cond == microwordPkg::condVmaInc};

endmodule

/* source/conoRegisters.sv */
// CONO PI and PAG registers
`timescale 1ns/10ps
`include "ebox_settings.svh"

module conoRegisters (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`EBOX_COND_WIDTH-1:0] cond,
  input  microwordPkg::magicWord      magic,
  input  logic [`EBOX_DATA_WIDTH-1:0] ebusData,
  output logic                        cacheLookEn,
  output logic                        cacheLoadEn,
  output logic                        klPagingEn,
  output logic                        trapEn,
  output logic [2:0]                  wrEvenPar
);

  logic conoSel;
  logic conoPi;
  logic conoPag;

  // Magic function 01x with the function enabled
  assign conoSel = (cond == microwordPkg::condDiagFunc) &&
                   !magic.diagFunc.noFunc &&
                   (magic.diagFunc.op == microwordPkg::magicOpCono);

  assign conoPi  = conoSel && (magic.diagFunc.sub == microwordPkg::magicSubConoPi);
  assign conoPag = conoSel && (magic.diagFunc.sub == microwordPkg::magicSubConoPag);

  always_ff @(posedge clk) begin
    if (reset) begin
      cacheLookEn <= 1'b0;
      cacheLoadEn <= 1'b0;
      klPagingEn  <= 1'b0;
      trapEn      <= 1'b0;
      wrEvenPar   <= 3'b000;
    end else begin
      if (conoPi) begin
        wrEvenPar <= ebusData[2:0];
      end
      // Paging enables, look enable in bit 3
      if (conoPag) begin
        {cacheLookEn, cacheLoadEn, klPagingEn, trapEn} <= ebusData[3:0];
      end
    end
  end

endmodule

/* source/cycleControl.sv */
// Cycle and state flags
`timescale 1ns/10ps
`include "ebox_settings.svh"

module cycleControl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`EBOX_COND_WIDTH-1:0] cond,
  input  microwordPkg::magicWord      magic,
  input  logic                        memWait,
  input  logic                        mboxCycReq,
  input  logic                        xfer,
  input  logic                        run,
  input  logic                        mtrIntReq,
  input  logic                        piReady,
  output logic                        memCycle,
  output logic                        mboxWait,
  output logic                        piCycle,
  output logic [3:0]                  ucodeState,
  output logic [2:0]                  nicond
);

  logic       specInstr;
  logic       eboxState;
  logic [2:0] nicondNext;

  assign specInstr = (cond == microwordPkg::condSpecInstr);
  assign eboxState = (cond == microwordPkg::condEboxState);
  assign mboxWait  = memWait & memCycle;

  // Next-instruction dispatch priority
  always_comb begin
    if (piCycle)            nicondNext = 3'd1;
    else if (!run)          nicondNext = 3'd2;
    else if (mtrIntReq)     nicondNext = 3'd3;
    else if (piReady)       nicondNext = 3'd4;
    else if (ucodeState[2]) nicondNext = 3'd5;
    else                    nicondNext = 3'd0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      memCycle   <= 1'b0;
      piCycle    <= 1'b0;
      ucodeState <= 4'b0000;
      nicond     <= 3'd0;
    end else begin
      memCycle <= mboxCycReq | (memCycle & ~xfer);
      // Magic bit 0 sets, bit 2 clears
      if (specInstr && magic[0]) begin
        piCycle <= 1'b1;
      end else if (specInstr && magic[2]) begin
        piCycle <= 1'b0;
      end
      if (eboxState) begin
        for (int i = 0; i < 4; i++) begin
          ucodeState[i] <= magic.statePairs.pair[i].set |
                           (magic.statePairs.pair[i].keep & ucodeState[i]);
        end
      end
      nicond <= nicondNext;
    end
  end

endmodule

/* source/diagConsole.sv */
// Diagnostic console port
`timescale 1ns/10ps
`include "ebox_settings.svh"

module diagConsole (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        diagReq,
  input  logic [3:0]                  diagFunc,
  input  logic                        cacheLookEn,
  input  logic                        cacheLoadEn,
  input  logic                        klPagingEn,
  input  logic                        trapEn,
  input  logic [2:0]                  wrEvenPar,
  input  logic                        memCycle,
  input  logic                        piCycle,
  input  logic                        mboxWait,
  input  logic [2:0]                  nicond,
  input  logic [3:0]                  ucodeState,
  output logic                        diagAck,
  output logic [`EBOX_DATA_WIDTH-1:0] diagRdData,
  output logic                        run,
  output logic                        start
);

  logic                         take;
  logic                         runReq;
  logic                         contPending;
  logic [`EBOX_SYNC_STAGES-1:0] runSync;
  logic [`EBOX_SYNC_STAGES-1:0] startSync;
  logic                         startPrev;
  logic [`EBOX_DATA_WIDTH-1:0]  readback;

  // New request only once the previous ack has dropped
  assign take = diagReq & ~diagAck;

  always_comb begin
    readback = '0;
    if (!diagFunc[3]) begin
      case (diagFunc[2:0])
        diagPkg::statusCono:
          readback = {cacheLookEn, cacheLoadEn, klPagingEn, trapEn, wrEvenPar, 1'b0};
        diagPkg::statusCycle:
          readback = {run, memCycle, piCycle, mboxWait, 1'b0, nicond};
        diagPkg::statusUcode:
          readback = {ucodeState, 4'b0000};
        default:
          readback = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      diagAck     <= 1'b0;
      runReq      <= 1'b0;
      contPending <= 1'b0;
      runSync     <= '0;
      startSync   <= '0;
      startPrev   <= 1'b0;
    end else begin
      if (take) begin
        diagAck <= 1'b1;
      end else if (!diagReq) begin
        diagAck <= 1'b0;
      end
      if (take && diagFunc == diagPkg::diagClrRun) begin
        runReq <= 1'b0;
      end else if (take && diagFunc == diagPkg::diagSetRun) begin
        runReq <= 1'b1;
      end
      if (take && diagFunc == diagPkg::diagContinue) begin
        contPending <= 1'b1;
      end else if (start) begin
        contPending <= 1'b0;
      end
      runSync   <= {runSync[`EBOX_SYNC_STAGES-2:0], runReq};
      startSync <= {startSync[`EBOX_SYNC_STAGES-2:0], contPending};
      startPrev <= startSync[`EBOX_SYNC_STAGES-1];
    end
  end

  // Status held for the whole ack phase
  always_ff @(posedge clk) begin
    if (take) begin
      diagRdData <= readback;
    end
  end

  assign run = runSync[`EBOX_SYNC_STAGES-1];

  // One pulse on the rising edge of the synchronized flag
  assign start = startSync[`EBOX_SYNC_STAGES-1] & ~startPrev;

endmodule

/* source/diagPkg.sv */
// Diagnostic console codes
package diagPkg;

  // Control functions, bit 3 set
  typedef enum logic [3:0] {
    diagClrRun   = 4'b1000,
    diagSetRun   = 4'b1001,
    diagContinue = 4'b1010
  } diagFunc_e;

  // Status word selects for read functions 0sss
  typedef enum logic [2:0] {
    statusCono  = 3'd0,
    statusCycle = 3'd1,
    statusUcode = 3'd2
  } statusSel;

  // Codes above statusUcode read back as zero

endpackage

/* source/eboxControl.sv */
// EBOX control board
`timescale 1ns/10ps
`include "ebox_settings.svh"

module eboxControl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`EBOX_COND_WIDTH-1:0] cond,
  input  microwordPkg::magicWord      magic,
  input  logic                        memWait,
  input  logic                        userMode,
  input  logic                        publicMode,
  input  logic                        ioLegalIr,
  input  logic                        piReady,
  input  logic                        mtrIntReq,
  input  logic                        vmaFetch,
  input  logic                        mboxCycReq,
  input  logic                        xfer,
  input  logic [`EBOX_DATA_WIDTH-1:0] ebusData,
  input  logic                        diagReq,
  input  logic [3:0]                  diagFunc,
  output logic                        skip,
  output logic                        loadIr,
  output logic [1:0]                  vmaSel,
  output logic                        run,
  output logic                        memCycle,
  output logic                        mboxWait,
  output logic                        piCycle,
  output logic [2:0]                  nicond,
  output logic                        diagAck,
  output logic [`EBOX_DATA_WIDTH-1:0] diagRdData
);

  logic       cacheLookEn;
  logic       cacheLoadEn;
  logic       klPagingEn;
  logic       trapEn;
  logic [2:0] wrEvenPar;
  logic [3:0] ucodeState;
  logic       start;

  condDecoder i_condDecoder (
    .cond(cond), .userMode(userMode), .publicMode(publicMode),
    .ioLegalIr(ioLegalIr), .piReady(piReady), .mtrIntReq(mtrIntReq),
    .vmaFetch(vmaFetch), .memCycle(memCycle), .mboxWait(mboxWait),
    .xfer(xfer), .piCycle(piCycle), .run(run), .start(start),
    .trapEn(trapEn), .klPagingEn(klPagingEn), .cacheLookEn(cacheLookEn),
    .skip(skip), .loadIr(loadIr), .vmaSel(vmaSel)
  );

  conoRegisters i_conoRegisters (
    .clk(clk), .reset(reset), .cond(cond), .magic(magic), .ebusData(ebusData),
    .cacheLookEn(cacheLookEn), .cacheLoadEn(cacheLoadEn),
    .klPagingEn(klPagingEn), .trapEn(trapEn), .wrEvenPar(wrEvenPar)
  );

  cycleControl i_cycleControl (
    .clk(clk), .reset(reset), .cond(cond), .magic(magic), .memWait(memWait),
    .mboxCycReq(mboxCycReq), .xfer(xfer), .run(run),
    .mtrIntReq(mtrIntReq), .piReady(piReady),
    .memCycle(memCycle), .mboxWait(mboxWait), .piCycle(piCycle),
    .ucodeState(ucodeState), .nicond(nicond)
  );

  diagConsole i_diagConsole (
    .clk(clk), .reset(reset), .diagReq(diagReq), .diagFunc(diagFunc),
    .cacheLookEn(cacheLookEn), .cacheLoadEn(cacheLoadEn),
    .klPagingEn(klPagingEn), .trapEn(trapEn), .wrEvenPar(wrEvenPar),
    .memCycle(memCycle), .piCycle(piCycle), .mboxWait(mboxWait),
    .nicond(nicond), .ucodeState(ucodeState),
    .diagAck(diagAck), .diagRdData(diagRdData), .run(run), .start(start)
  );

endmodule

/* source/ebox_settings.svh */
// EBOX control widths
`ifndef EBOX_SETTINGS_SVH
`define EBOX_SETTINGS_SVH

// Microword condition field
`define EBOX_COND_WIDTH 6

// Microword magic number field
`define EBOX_MAGIC_WIDTH 9

// EBUS data and console data
`define EBOX_DATA_WIDTH 8

// RUN and START synchronizer depth
`define EBOX_SYNC_STAGES 3

`endif

/* source/microwordPkg.sv */
// Microword field definitions
`include "ebox_settings.svh"

package microwordPkg;

  // Condition codes, octal
  localparam logic [`EBOX_COND_WIDTH-1:0] condLoadIr    = 6'o14;
  localparam logic [`EBOX_COND_WIDTH-1:0] condSpecInstr = 6'o15;
  localparam logic [`EBOX_COND_WIDTH-1:0] condDiagFunc  = 6'o20;
  localparam logic [`EBOX_COND_WIDTH-1:0] condEboxState = 6'o21;
  localparam logic [`EBOX_COND_WIDTH-1:0] condVmaDec    = 6'o35;
  localparam logic [`EBOX_COND_WIDTH-1:0] condVmaInc    = 6'o36;

  // Skip groups in the top three condition bits
  localparam logic [2:0] condGroupSkip60 = 3'd6;
  localparam logic [2:0] condGroupSkip70 = 3'd7;

  // Magic function decode for CONO
  localparam logic [2:0] magicOpCono     = 3'd1;
  localparam logic [2:0] magicSubConoPi  = 3'd5;
  localparam logic [2:0] magicSubConoPag = 3'd6;

  typedef struct packed {
    logic [2:0] sub;
    logic [2:0] op;
    logic noFunc;
    logic [`EBOX_MAGIC_WIDTH-8:0] spare;
  } diagFuncView;

  typedef struct packed {
    logic keep;
    logic set;
  } statePair;

  // Pair 0 sits at bits 2:1, pair 3 at bits 8:7
  typedef struct packed {
    statePair [3:0] pair;
    logic [`EBOX_MAGIC_WIDTH-9:0] spare;
  } statePairView;

  typedef union packed {
    diagFuncView diagFunc;
    statePairView statePairs;
  } magicWord;

endpackage
